/* bench/apb_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_subsystem_tb;

    localparam int          PERIOD    = 20;
    localparam int          DRIVE_DLY = 2;
    localparam int          TIMEOUT   = 1000;
    localparam int          NUM_RAND  = 200;
    localparam logic [31:0] SEED      = 32'h182f8864;

    logic                   pclk;
    logic                   rst;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic                   cmd_write;
    logic [`APB_ADDR_W-1:0] cmd_addr;
    logic [`APB_DATA_W-1:0] cmd_wdata;
    logic [`APB_STRB_W-1:0] cmd_strb;
    logic [`APB_PROT_W-1:0] cmd_prot;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [`APB_DATA_W-1:0] rsp_rdata;
    logic                   rsp_slverr;

    int          errors;
    int          checks;
    int          sent;
    logic [31:0] lfsr;

    // Register model, index is slot * 4 + register
    logic [`APB_DATA_W-1:0] model [16];

    // Expected responses in command order
    logic [`APB_DATA_W-1:0] exp_data [$];
    logic                   exp_err  [$];
    logic                   exp_chk  [$];

    apb_subsystem u_dut (
        .pclk       (pclk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_strb   (cmd_strb),
        .cmd_prot   (cmd_prot),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .rsp_slverr (rsp_slverr)
    );

    initial begin
        pclk = 1'b0;
        forever begin
            #(PERIOD / 2) pclk = ~pclk;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [`APB_ADDR_W-1:0] reg_addr(input int i);
        logic [3:0] v;
        v = i[3:0];
        return {2'b00, v[3:2], 4'h0, v[1:0], 2'b00};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Update the model and queue the response this command should get
    task automatic predict(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic [2:0] prot);
        int          idx;
        logic [31:0] merged;
        idx = {addr[`APB_SLOT_LSB +: 2], addr[`APB_REG_LSB +: 2]};
        if (addr[`APB_ADDR_W-1:`APB_MAP_TOP_LSB] != '0) begin
            exp_data.push_back('0);
            exp_err.push_back(1'b1);
            exp_chk.push_back(1'b1);
        end else if (!wr) begin
            exp_data.push_back(model[idx]);
            exp_err.push_back(1'b0);
            exp_chk.push_back(1'b1);
        end else if (addr[`APB_REG_LSB +: 2] == `APB_LOCK_REG && !prot[`APB_PRIV_BIT]) begin
            exp_data.push_back('0);
            exp_err.push_back(1'b1);
            exp_chk.push_back(1'b0);
        end else begin
            merged = model[idx];
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
            end
            model[idx] = merged;
            exp_data.push_back('0);
            exp_err.push_back(1'b0);
            exp_chk.push_back(1'b0);
        end
    endtask

    // Called and left 2 ns after a rising edge
    task automatic send_cmd(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            input logic [2:0] prot);
        int waited;
        bit done;
        waited    = 0;
        done      = 1'b0;
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_strb  = strb;
        cmd_prot  = prot;
        while (!done && waited < TIMEOUT) begin
            @(negedge pclk);
            if (cmd_ready) begin
                done = 1'b1;
                predict(wr, addr, wdata, strb, prot);
                sent++;
            end
            @(posedge pclk);
            #DRIVE_DLY;
            waited++;
        end
        cmd_valid = 1'b0;
        if (!done) begin
            $display("Timed out at %0t ns waiting for cmd_ready", $time);
            errors++;
        end
    endtask

    task automatic get_rsp(input bit throttle);
        int waited;
        bit got;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < TIMEOUT) begin
            rsp_ready = throttle ? lfsr_bit() : 1'b1;
            @(negedge pclk);
            if (rsp_valid && rsp_ready) begin
                got = 1'b1;
                if (exp_err.size() == 0) begin
                    $display("Response at %0t ns with no command outstanding", $time);
                    errors++;
                end else begin
                    check(rsp_slverr, exp_err.pop_front(), "slverr");
                    if (exp_chk.pop_front()) begin
                        check(rsp_rdata, exp_data.pop_front(), "rdata");
                    end else begin
                        void'(exp_data.pop_front());
                    end
                end
            end
            @(posedge pclk);
            #DRIVE_DLY;
            waited++;
        end
        rsp_ready = 1'b0;
        if (!got) begin
            $display("Timed out at %0t ns waiting for rsp_valid", $time);
            errors++;
        end
    endtask

    task automatic do_cmd(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [2:0] prot);
        send_cmd(wr, addr, wdata, strb, prot);
        get_rsp(1'b0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic test_write_read();
        int e0;
        e0 = errors;
        // Registers start at zero
        for (int i = 0; i < 16; i++) do_cmd(1'b0, reg_addr(i), '0, 4'h0, 3'b000);
        for (int i = 0; i < 16; i++) begin
            do_cmd(1'b1, reg_addr(i), 32'ha5000000 ^ (i * 32'h01010101) + i, 4'hf, 3'b001);
        end
        for (int i = 0; i < 16; i++) do_cmd(1'b0, reg_addr(i), '0, 4'h0, 3'b000);
        report_test("write_read", e0);
    endtask

    task automatic test_byte_strobes();
        int e0;
        e0 = errors;
        do_cmd(1'b1, reg_addr(6), 32'h11223344, 4'hf, 3'b000);
        do_cmd(1'b1, reg_addr(6), 32'haabbccdd, 4'b0001, 3'b000);
        do_cmd(1'b0, reg_addr(6), '0, 4'h0, 3'b000);
        do_cmd(1'b1, reg_addr(6), 32'h55667788, 4'b0110, 3'b000);
        do_cmd(1'b0, reg_addr(6), '0, 4'h0, 3'b000);
        do_cmd(1'b1, reg_addr(6), 32'h99eeff00, 4'b1000, 3'b000);
        do_cmd(1'b0, reg_addr(6), '0, 4'h0, 3'b000);
        report_test("byte_strobes", e0);
    endtask

    task automatic test_protected_reg();
        int e0;
        e0 = errors;
        do_cmd(1'b1, reg_addr(3), 32'hdeadbeef, 4'hf, 3'b000);
        do_cmd(1'b0, reg_addr(3), '0, 4'h0, 3'b000);
        do_cmd(1'b1, reg_addr(3), 32'hdeadbeef, 4'hf, 3'b001);
        do_cmd(1'b0, reg_addr(3), '0, 4'h0, 3'b000);
        do_cmd(1'b0, reg_addr(3), '0, 4'h0, 3'b001);
        report_test("protected_reg", e0);
    endtask

    task automatic test_unmapped();
        int e0;
        e0 = errors;
        do_cmd(1'b0, 12'h400, '0, 4'h0, 3'b001);
        do_cmd(1'b1, 12'h8f4, 32'h12345678, 4'hf, 3'b001);
        do_cmd(1'b1, 12'hc00, 32'hcafef00d, 4'hf, 3'b000);
        do_cmd(1'b0, 12'hd0c, '0, 4'h0, 3'b000);
        for (int i = 0; i < 16; i++) do_cmd(1'b0, reg_addr(i), '0, 4'h0, 3'b000);
        report_test("unmapped", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int waited;
        bit dropped;
        e0      = errors;
        sent    = 0;
        waited  = 0;
        dropped = 1'b0;
        fork
            begin
                for (int k = 0; k < 10; k++) begin
                    send_cmd(k < 5, reg_addr(8 + k % 4), 32'hb0b00000 + k, 4'hf, 3'b001);
                end
            end
            begin
                // Responses held back until the command queue backs up
                while (!dropped && waited < 200) begin
                    @(negedge pclk);
                    if (!cmd_ready) dropped = 1'b1;
                    @(posedge pclk);
                    #DRIVE_DLY;
                    waited++;
                end
                if (dropped) begin
                    check(sent < 10, 1'b1, "cmd_ready low before ten commands accepted");
                end else begin
                    $display("cmd_ready never dropped while responses were held back");
                    errors++;
                end
                for (int k = 0; k < 10; k++) get_rsp(1'b0);
            end
        join
        report_test("back_pressure", e0);
    endtask

    task automatic test_random();
        int                     e0;
        logic [`APB_ADDR_W-1:0] r_addr  [NUM_RAND];
        logic [31:0]            r_data  [NUM_RAND];
        logic [3:0]             r_strb  [NUM_RAND];
        logic                   r_write [NUM_RAND];
        logic [2:0]             r_prot  [NUM_RAND];
        e0 = errors;
        // Drawn up front so only the response side steps the LFSR later
        for (int k = 0; k < NUM_RAND; k++) begin
            r_addr[k] = rand_bits(12);
            if (rand_bits(2) != 0) r_addr[k][11:10] = 2'b00;
            r_write[k] = rand_bits(1);
            r_strb[k]  = rand_bits(4);
            r_prot[k]  = {2'b00, rand_bits(1) == 1};
            r_data[k]  = rand_bits(32);
        end
        fork
            begin
                for (int k = 0; k < NUM_RAND; k++) begin
                    send_cmd(r_write[k], r_addr[k], r_data[k], r_strb[k], r_prot[k]);
                end
            end
            begin
                for (int k = 0; k < NUM_RAND; k++) get_rsp(1'b1);
            end
        join
        report_test("random", e0);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        sent      = 0;
        lfsr      = SEED;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_strb  = '0;
        cmd_prot  = '0;
        rsp_ready = 1'b0;
        for (int i = 0; i < 16; i++) model[i] = '0;
        repeat (4) @(posedge pclk);
        #DRIVE_DLY;
        rst = 1'b0;
        check(cmd_ready, 1'b1, "cmd_ready after reset");
        check(rsp_valid, 1'b0, "rsp_valid after reset");

        test_write_read();
        test_byte_strobes();
        test_protected_reg();
        test_unmapped();
        test_back_pressure();
        test_random();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/apb_pkg.sv
verilog/apb_if.sv
verilog/apb_fifo.sv
verilog/apb_master.sv
verilog/apb_decoder.sv
verilog/apb_reg_slave.sv
verilog/apb_return_mux.sv
verilog/apb_subsystem.sv
bench/apb_subsystem_tb.sv

/* verilog/apb_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_decoder (
    apb_if.decode                  bus,
    apb_if.master                  slv [`APB_NUM_SLAVES],
    output logic [`APB_SLOT_W-1:0] slot,
    output logic                   hit
);

    // Mapped only when the top address bits are clear
    assign hit  = (bus.paddr[`APB_ADDR_W-1:`APB_MAP_TOP_LSB] == '0);
    assign slot = bus.paddr[`APB_SLOT_LSB +: `APB_SLOT_W];

    for (genvar i = 0; i < `APB_NUM_SLAVES; i++) begin : g_fanout
        // One select at most, never on a miss
        assign slv[i].psel    = bus.psel && hit && (slot == `APB_SLOT_W'(i));

        // Shared request fields
        assign slv[i].penable = bus.penable;
        assign slv[i].paddr   = bus.paddr;
        assign slv[i].pwrite  = bus.pwrite;
        assign slv[i].pwdata  = bus.pwdata;
        assign slv[i].pstrb   = bus.pstrb;
        assign slv[i].pprot   = bus.pprot;
    end

endmodule

`default_nettype wire

/* verilog/apb_defines.svh */
`ifndef APB_DEFINES_SVH
`define APB_DEFINES_SVH

// APB bus widths
`define APB_ADDR_W 12
`define APB_DATA_W 32
`define APB_STRB_W 4
`define APB_PROT_W 3

// Slave array
`define APB_NUM_SLAVES 4
`define APB_SLOT_W 2

// Queue depths, powers of two
`define APB_CMD_DEPTH 4
`define APB_RSP_DEPTH 4

// Address map fields
`define APB_SLOT_LSB 8
`define APB_REG_LSB 2
`define APB_MAP_TOP_LSB 10

// Protection
`define APB_PRIV_BIT 0
`define APB_LOCK_REG 3

`endif

/* verilog/apb_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  wire logic               pclk,
    input  wire logic               rst,
    input  wire logic               wr_valid,
    output logic                    wr_ready,
    input  wire logic [WIDTH-1:0]   wr_data,
    output logic                    rd_valid,
    input  wire logic               rd_ready,
    output logic [WIDTH-1:0]        rd_data,
    output logic [$clog2(DEPTH):0]  count
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign rd_valid = (count != '0);
    // A full FIFO still accepts a word when the head leaves this cycle
    assign wr_ready = (count < DEPTH) || rd_ready;

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    assign rd_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge pclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy never runs past the buffer
    assert property (@(posedge pclk) disable iff (rst) count <= DEPTH)
        else $error("apb_fifo: count above DEPTH");

endmodule

`default_nettype wire

/* verilog/apb_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

interface apb_if;

    // Request side
    logic                   psel;
    logic                   penable;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_STRB_W-1:0] pstrb;
    logic [`APB_PROT_W-1:0] pprot;

    // Return side
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    modport master (
        output psel, penable, paddr, pwrite, pwdata, pstrb, pprot,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, paddr, pwrite, pwdata, pstrb, pprot,
        output prdata, pready, pslverr
    );

    // Address decode view of the upstream bus
    modport decode (
        input  psel, penable, paddr, pwrite, pwdata, pstrb, pprot
    );

    modport ret (
        input  prdata, pready, pslverr
    );

endinterface

`default_nettype wire

/* verilog/apb_master.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_master (
    input  wire logic              pclk,
    input  wire logic              rst,
    input  wire logic              cmd_valid,
    output logic                   cmd_ready,
    input  wire apb_pkg::apb_cmd_t cmd_in,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output apb_pkg::apb_rsp_t      rsp_out,
    apb_if.master                  bus
);

    localparam int CMD_W     = $bits(apb_pkg::apb_cmd_t);
    localparam int RSP_W     = $bits(apb_pkg::apb_rsp_t);
    localparam int CMD_CNT_W = $clog2(`APB_CMD_DEPTH) + 1;
    localparam int RSP_CNT_W = $clog2(`APB_RSP_DEPTH) + 1;

    apb_pkg::apb_state_e  state;
    apb_pkg::apb_state_e  state_next;

    apb_pkg::apb_cmd_t    cmd_head;
    logic                 cmd_head_valid;
    logic [CMD_CNT_W-1:0] cmd_count;

    apb_pkg::apb_rsp_t    rsp_word;
    logic                 rsp_space;
    logic [RSP_CNT_W-1:0] rsp_count;

    logic                 done;
    logic                 more;

    apb_fifo #(
        .WIDTH (CMD_W),
        .DEPTH (`APB_CMD_DEPTH)
    ) u_cmd_fifo (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (cmd_valid),
        .wr_ready (cmd_ready),
        .wr_data  (cmd_in),
        .rd_valid (cmd_head_valid),
        .rd_ready (done),
        .rd_data  (cmd_head),
        .count    (cmd_count)
    );

    // Space is checked before SETUP, so this push is never refused
    apb_fifo #(
        .WIDTH (RSP_W),
        .DEPTH (`APB_RSP_DEPTH)
    ) u_rsp_fifo (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (done),
        .wr_ready (rsp_space),
        .wr_data  (rsp_word),
        .rd_valid (rsp_valid),
        .rd_ready (rsp_ready),
        .rd_data  (rsp_out),
        .count    (rsp_count)
    );

    // Request fields straight from the command FIFO head
    assign bus.paddr   = cmd_head.addr;
    assign bus.pwrite  = cmd_head.write;
    assign bus.pwdata  = cmd_head.wdata;
    assign bus.pstrb   = cmd_head.strb;
    assign bus.pprot   = cmd_head.prot;
    assign bus.psel    = (state != apb_pkg::IDLE);
    assign bus.penable = (state == apb_pkg::ACCESS);

    assign rsp_word.slverr = bus.pslverr;
    assign rsp_word.rdata  = bus.prdata;

    assign done = (state == apb_pkg::ACCESS) && bus.pready;

    // Another command behind the head, with room left for its response
    assign more = (cmd_count > 1) &&
                  ((rsp_count < (`APB_RSP_DEPTH - 1)) || (rsp_valid && rsp_ready));

    always_ff @(posedge pclk) begin
        if (rst) begin
            state <= apb_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            apb_pkg::IDLE: begin
                if (cmd_head_valid && rsp_space) begin
                    state_next = apb_pkg::SETUP;
                end
            end
            apb_pkg::SETUP: begin
                state_next = apb_pkg::ACCESS;
            end
            apb_pkg::ACCESS: begin
                if (bus.pready) begin
                    state_next = more ? apb_pkg::SETUP : apb_pkg::IDLE;
                end
            end
            default: begin
                state_next = apb_pkg::IDLE;
            end
        endcase
    end

    // A completed transfer always finds room for its response
    assert property (@(posedge pclk) disable iff (rst) done |-> rsp_space)
        else $error("apb_master: response FIFO full at transfer end");

    // Address held from SETUP until the slave completes
    assert property (@(posedge pclk) disable iff (rst)
        (bus.psel && !(bus.penable && bus.pready)) |=> $stable(bus.paddr))
        else $error("apb_master: paddr changed mid-transfer");

endmodule

`default_nettype wire

/* verilog/apb_pkg.sv */
`default_nettype none

`include "apb_defines.svh"

package apb_pkg;

    // Master FSM
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    // One queued host command
    typedef struct packed {
        logic                   write;
        logic [`APB_PROT_W-1:0] prot;
        logic [`APB_STRB_W-1:0] strb;
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
    } apb_cmd_t;

    // Result of one APB transfer, read or write
    typedef struct packed {
        logic                   slverr;
        logic [`APB_DATA_W-1:0] rdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/apb_reg_slave.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_reg_slave (
    input wire logic pclk,
    input wire logic rst,
    apb_if.slave     bus
);

    localparam int NUM_REGS = 4;
    localparam int IDX_W    = $clog2(NUM_REGS);

    logic [`APB_DATA_W-1:0] regs [NUM_REGS];
    logic [`APB_DATA_W-1:0] merged;
    logic [IDX_W-1:0]       idx;
    logic                   access;
    logic                   wait_done;
    logic                   refused;

    assign idx    = bus.paddr[`APB_REG_LSB +: IDX_W];
    assign access = bus.psel && bus.penable;

    // Locked register takes privileged writes only
    assign refused = bus.pwrite && (idx == IDX_W'(`APB_LOCK_REG)) &&
                     !bus.pprot[`APB_PRIV_BIT];

    // Fixed single wait state, ready in the second ACCESS cycle
    always_ff @(posedge pclk) begin
        if (rst) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= access && !wait_done;
        end
    end

    assign bus.pready  = wait_done;
    assign bus.pslverr = wait_done && refused;
    assign bus.prdata  = regs[idx];

    // Byte lanes under strobe, rest kept
    always_comb begin
        for (int b = 0; b < `APB_STRB_W; b++) begin
            merged[8*b +: 8] = bus.pstrb[b] ? bus.pwdata[8*b +: 8] : regs[idx][8*b +: 8];
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (access && wait_done && bus.pwrite && !refused) begin
            regs[idx] <= merged;
        end
    end

    // Master keeps ACCESS up until this slave answers
    assert property (@(posedge pclk) disable iff (rst)
        bus.pready |-> (bus.psel && bus.penable))
        else $error("apb_reg_slave: pready outside ACCESS");

endmodule

`default_nettype wire

/* verilog/apb_return_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_return_mux (
    input wire logic [`APB_SLOT_W-1:0] slot,
    input wire logic                   hit,
    apb_if.ret                         slv [`APB_NUM_SLAVES],
    apb_if.slave                       bus
);

    logic [`APB_DATA_W-1:0] prdata_a  [`APB_NUM_SLAVES];
    logic                   pready_a  [`APB_NUM_SLAVES];
    logic                   pslverr_a [`APB_NUM_SLAVES];

    // Flatten the interface array so it can be indexed by slot
    for (genvar i = 0; i < `APB_NUM_SLAVES; i++) begin : g_gather
        assign prdata_a[i]  = slv[i].prdata;
        assign pready_a[i]  = slv[i].pready;
        assign pslverr_a[i] = slv[i].pslverr;
    end

    always_comb begin
        if (hit) begin
            bus.prdata  = prdata_a[slot];
            bus.pready  = pready_a[slot];
            bus.pslverr = pslverr_a[slot];
        end else begin
            // Unmapped, error in the first ACCESS cycle
            bus.prdata  = '0;
            bus.pready  = bus.psel && bus.penable;
            bus.pslverr = bus.psel && bus.penable;
        end
    end

endmodule

`default_nettype wire

/* verilog/apb_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_defines.svh"

module apb_subsystem (
    input  wire logic                   pclk,
    input  wire logic                   rst,
    input  wire logic                   cmd_valid,
    output logic                        cmd_ready,
    input  wire logic                   cmd_write,
    input  wire logic [`APB_ADDR_W-1:0] cmd_addr,
    input  wire logic [`APB_DATA_W-1:0] cmd_wdata,
    input  wire logic [`APB_STRB_W-1:0] cmd_strb,
    input  wire logic [`APB_PROT_W-1:0] cmd_prot,
    output logic                        rsp_valid,
    input  wire logic                   rsp_ready,
    output logic [`APB_DATA_W-1:0]      rsp_rdata,
    output logic                        rsp_slverr
);

    apb_pkg::apb_cmd_t      cmd_word;
    apb_pkg::apb_rsp_t      rsp_word;
    logic [`APB_SLOT_W-1:0] slot;
    logic                   hit;

    apb_if bus_m ();
    apb_if slv_bus [`APB_NUM_SLAVES] ();

    assign cmd_word.write = cmd_write;
    assign cmd_word.prot  = cmd_prot;
    assign cmd_word.strb  = cmd_strb;
    assign cmd_word.addr  = cmd_addr;
    assign cmd_word.wdata = cmd_wdata;

    assign rsp_rdata  = rsp_word.rdata;
    assign rsp_slverr = rsp_word.slverr;

    apb_master u_master (
        .pclk      (pclk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_in    (cmd_word),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_out   (rsp_word),
        .bus       (bus_m)
    );

    apb_decoder u_decoder (
        .bus  (bus_m),
        .slv  (slv_bus),
        .slot (slot),
        .hit  (hit)
    );

    for (genvar i = 0; i < `APB_NUM_SLAVES; i++) begin : g_slave
        apb_reg_slave u_slave (
            .pclk (pclk),
            .rst  (rst),
            .bus  (slv_bus[i])
        );
    end

    apb_return_mux u_return_mux (
        .slot (slot),
        .hit  (hit),
        .slv  (slv_bus),
        .bus  (bus_m)
    );

endmodule

`default_nettype wire
